// ==== filelist.f ====
rtl/lstm_pkg.sv
rtl/param_loader.sv
rtl/param_ram.sv
rtl/step_ctrl.sv
rtl/dot_product.sv
rtl/cell_update.sv
rtl/lstm_top.sv
test/lstm_properties.sv
test/lstm_tb.sv

// ==== Makefile ====
# Verilator build and run of the LSTM cell testbench

VERILATOR ?= verilator
TOP ?= lstm_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
RUN_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Testbench passed

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Verdict comes from the log, not from the exit status of the model
run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/lstm_tb.sv ====
// LSTM cell testbench with reference model, compare tasks and cycle watchdog
// Random and extreme parameter loads, chained, reloaded and back-to-back steps
`timescale 1ns/100ps

module lstm_tb;

	localparam int LOAD_BYTES = 32 * 16 + 32;
	localparam int N_LOADS = 3;
	localparam int N_STEPS = 25;
	localparam int CYCLE_LIMIT = (N_LOADS * LOAD_BYTES + N_STEPS * 40) * 2;
	localparam int N_BURST = 6;

	// Quantization constants of the reference model
	localparam int REF_ZERO = 128;
	localparam int REF_S_SIG = 24;
	localparam int REF_S_TANH = 48;
	localparam int REF_S_WD = 128 * 128;
	localparam int REF_S_B = 256;
	localparam int REF_S_STATE = 128;
	localparam int REF_S_DATA = 128;
	localparam int REF_OUT_SIG = 256;
	localparam int REF_OUT_TANH = 128;

	logic clk;
	logic resetn;
	logic init_valid;
	logic init_type;
	logic [7:0] init_data;
	logic step_valid;
	logic [lstm_pkg::N_IN*8-1:0] step_x;
	logic init_ready;
	logic step_ready;
	logic step_done;
	logic [lstm_pkg::N_HID*8-1:0] ct;
	logic [lstm_pkg::N_HID*8-1:0] ht;

	// Parameters kept in load order, row n and bias byte n
	logic [7:0] w_rows [32][16];
	logic [7:0] b_bytes [32];
	logic [63:0] ref_c;
	logic [63:0] ref_h;
	logic [127:0] exp_q [$];
	logic [31:0] rng;
	int value_errs = 0;
	int other_errs = 0;
	int cycle_cnt = 0;

	always #2 clk = ~clk;

	lstm_top u_lstm_top (
		.clk(clk), .resetn(resetn), .init_valid(init_valid), .init_type(init_type),
		.init_data(init_data), .step_valid(step_valid), .step_x(step_x),
		.init_ready(init_ready), .step_ready(step_ready), .step_done(step_done),
		.ct(ct), .ht(ht)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic [7:0] next_byte();
		rng = xorshift(rng);
		return rng[15:8];
	endfunction

	function automatic logic [63:0] rand_vec();
		logic [63:0] v;
		for (int i = 0; i < 8; i++)
			v[63-8*i -: 8] = next_byte();
		return v;
	endfunction

	function automatic int clamp8(input int v);
		return (v < 0) ? 0 : ((v > 255) ? 255 : v);
	endfunction

	function automatic int hard_act(input int q);
		return clamp8(REF_ZERO + (q - REF_ZERO) * 8 / 3);
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model, returns {new ct, new ht}
	////////////////////////////////////////////////////////////
	function automatic logic [127:0] ref_step(input logic [63:0] x, input logic [63:0] c_in,
		input logic [63:0] h_in);
		int d [16];
		int gate [4];
		int acc;
		int s;
		int n;
		int cv;
		int cn;
		int tv;
		int hv;
		logic [63:0] c_new;
		logic [63:0] h_new;
		for (int t = 0; t < 8; t++) begin
			d[t] = int'(x[63-8*t -: 8]) - REF_ZERO;
			d[t+8] = int'(h_in[63-8*t -: 8]) - REF_ZERO;
		end
		for (int u = 0; u < 8; u++) begin
			for (int g = 0; g < 4; g++) begin
				// Row 2*(4k+g)+lane holds gate g of unit 2k+lane
				n = 2 * (4 * (u / 2) + g) + u % 2;
				acc = 0;
				for (int t = 0; t < 16; t++)
					acc = acc + d[t] * (int'(w_rows[n][t]) - 128);
				s = (g == 2) ? REF_S_TANH : REF_S_SIG;
				gate[g] = hard_act(clamp8(acc * s / REF_S_WD + int'(b_bytes[n]) * s / REF_S_B
					+ REF_ZERO));
			end
			cv = int'(c_in[63-8*u -: 8]) - REF_ZERO;
			cn = clamp8(cv * gate[0] / REF_OUT_SIG + gate[1] * (gate[2] - REF_ZERO)
				* REF_S_STATE / (REF_OUT_SIG * REF_OUT_TANH) + REF_ZERO);
			tv = hard_act(clamp8((cn - REF_ZERO) * REF_S_TANH / REF_S_STATE + REF_ZERO));
			hv = clamp8(gate[3] * (tv - REF_ZERO) * REF_S_DATA / (REF_OUT_TANH * REF_OUT_SIG)
				+ REF_ZERO);
			c_new[63-8*u -: 8] = 8'(cn);
			h_new[63-8*u -: 8] = 8'(hv);
		end
		return {c_new, h_new};
	endfunction

	task automatic check_ct(input logic [lstm_pkg::N_HID*8-1:0] got,
		input logic [lstm_pkg::N_HID*8-1:0] exp);
		for (int u = 0; u < 8; u++)
			if (got[63-8*u -: 8] !== exp[63-8*u -: 8]) begin
				$display("FAILED ct[%0d] got %h expected %h", u, got[63-8*u -: 8], exp[63-8*u -: 8]);
				value_errs++;
			end
	endtask

	task automatic check_ht(input logic [lstm_pkg::N_HID*8-1:0] got,
		input logic [lstm_pkg::N_HID*8-1:0] exp);
		for (int u = 0; u < 8; u++)
			if (got[63-8*u -: 8] !== exp[63-8*u -: 8]) begin
				$display("FAILED ht[%0d] got %h expected %h", u, got[63-8*u -: 8], exp[63-8*u -: 8]);
				value_errs++;
			end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	// Expected state for an accepted input, queued for the compare process
	task automatic accept_step(input logic [63:0] x);
		logic [127:0] e;
		e = ref_step(x, ref_c, ref_h);
		ref_c = e[127:64];
		ref_h = e[63:0];
		exp_q.push_back(e);
	endtask

	task automatic fill_random();
		for (int n = 0; n < 32; n++) begin
			for (int t = 0; t < 16; t++)
				w_rows[n][t] = next_byte();
			b_bytes[n] = next_byte();
		end
	endtask

	// Full positive weights, except the candidate gate of odd units
	task automatic fill_extreme();
		for (int n = 0; n < 32; n++) begin
			for (int t = 0; t < 16; t++)
				w_rows[n][t] = ((n / 2) % 4 == 2 && n % 2 == 1) ? 8'h00 : 8'hff;
			b_bytes[n] = 8'hff;
		end
	endtask

	task automatic send_byte(input logic kind, input logic [7:0] data);
		init_valid <= 1'b1;
		init_type <= kind;
		init_data <= data;
		do @(posedge clk); while (!init_ready);
	endtask

	task automatic load_params();
		for (int n = 0; n < 32; n++)
			for (int t = 0; t < 16; t++)
				send_byte(1'b0, w_rows[n][t]);
		for (int n = 0; n < 32; n++)
			send_byte(1'b1, b_bytes[n]);
		init_valid <= 1'b0;
	endtask

	task automatic run_step(input logic [63:0] x);
		step_valid <= 1'b1;
		step_x <= x;
		do @(posedge clk); while (!step_ready);
		step_valid <= 1'b0;
		accept_step(x);
		do @(posedge clk); while (!step_done);
	endtask

	// Compare process
	always @(posedge clk) begin
		logic [127:0] e;
		if (step_done) begin
			if (exp_q.size() == 0) begin
				$display("step_done pulsed with no step outstanding");
				other_errs++;
			end else begin
				e = exp_q.pop_front();
				check_ct(ct, e[127:64]);
				check_ht(ht, e[63:0]);
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
			$display("Errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
				u_lstm_top.u_props.fail_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	initial begin
		logic has_ff;
		logic has_00;
		logic [63:0] x;
		int accepts;
		int dones;
		clk = 1'b0;
		resetn = 1'b0;
		init_valid = 1'b0;
		init_type = 1'b0;
		init_data = 8'h00;
		step_valid = 1'b0;
		step_x = '0;
		rng = 32'd13;
		ref_c = {8{8'h80}};
		ref_h = {8{8'h80}};
		repeat (2) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		check_ct(ct, {8{8'h80}});
		check_ht(ht, {8{8'h80}});
		check_flag("step_done", step_done, 1'b0);
		check_flag("step_ready", step_ready, 1'b1);
		check_flag("init_ready", init_ready, 1'b1);

		fill_random();
		load_params();
		run_step(rand_vec());
		repeat (10) run_step(rand_vec());

		// Saturated gates push the cell state to both ends
		fill_extreme();
		load_params();
		repeat (4) run_step({8{8'hff}});
		has_ff = 1'b0;
		has_00 = 1'b0;
		for (int u = 0; u < 8; u++) begin
			has_ff |= ct[63-8*u -: 8] == 8'hff;
			has_00 |= ct[63-8*u -: 8] == 8'h00;
		end
		if (!(has_ff && has_00)) begin
			$display("Extreme parameters did not saturate ct to both 0x00 and 0xff");
			other_errs++;
		end

		fill_random();
		load_params();
		repeat (4) run_step(rand_vec());

		// step_valid held high across several steps
		accepts = 0;
		dones = 0;
		x = rand_vec();
		step_valid <= 1'b1;
		step_x <= x;
		while (dones < N_BURST) begin
			@(posedge clk);
			if (step_done)
				dones++;
			if (step_valid && step_ready) begin
				accept_step(x);
				accepts++;
				if (accepts == N_BURST) begin
					step_valid <= 1'b0;
				end else begin
					x = rand_vec();
					step_x <= x;
				end
			end
		end
		repeat (40) begin
			@(posedge clk);
			if (step_done)
				dones++;
		end
		if (dones != accepts || accepts != N_BURST) begin
			$display("Back-to-back steps gave %0d done pulses for %0d accepts", dones, accepts);
			other_errs++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d accepted steps never signalled step_done", exp_q.size());
			other_errs++;
		end

		$display("Errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
			u_lstm_top.u_props.fail_cnt);
		if (value_errs + other_errs + u_lstm_top.u_props.fail_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== test/lstm_properties.sv ====
// Concurrent checks on the step and init handshakes of the LSTM top level
`timescale 1ns/100ps

module lstm_properties (
	input  logic clk,
	input  logic resetn,
	input  logic init_ready,
	input  logic step_valid,
	input  logic step_ready,
	input  logic step_done
);

	localparam int DONE_LAT = 26;

	// Step in flight from accept to its done pulse
	logic in_step;
	logic [4:0] lat;
	int fail_cnt = 0;

	always @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			in_step <= 1'b0;
			lat <= '0;
		end else if (step_valid && step_ready) begin
			in_step <= 1'b1;
			lat <= 5'd1;
		end else if (step_done) begin
			in_step <= 1'b0;
			lat <= '0;
		end else if (in_step) begin
			lat <= lat + 5'd1;
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
		step_done |=> !step_done)
	else begin
		$error("step_done high for more than one cycle");
		fail_cnt++;
	end

	a_ready_low: assert property (@(posedge clk) disable iff (!resetn)
		in_step && !step_done |-> !step_ready)
	else begin
		$error("step_ready high while a step runs");
		fail_cnt++;
	end

	// No init byte can be taken while a step runs
	a_no_init: assert property (@(posedge clk) disable iff (!resetn)
		in_step && !step_done |-> !init_ready)
	else begin
		$error("init_ready high during a step");
		fail_cnt++;
	end

	// Done exactly at the fixed latency after accept
	a_latency: assert property (@(posedge clk) disable iff (!resetn)
		step_done |-> in_step && lat == 5'(DONE_LAT))
	else begin
		$error("step_done outside the fixed step latency");
		fail_cnt++;
	end

endmodule

bind lstm_top lstm_properties u_props (
	.clk(clk), .resetn(resetn), .init_ready(init_ready),
	.step_valid(step_valid), .step_ready(step_ready), .step_done(step_done)
);

// ==== rtl/lstm_top.sv ====
// LSTM cell top level
// Loader, parameter memories, step control, dot product and cell update
`timescale 1ns/100ps

module lstm_top (
	input  logic clk,
	input  logic resetn,
	input  logic init_valid,
	input  logic init_type,
	input  logic [7:0] init_data,
	input  logic step_valid,
	input  logic [lstm_pkg::N_IN*8-1:0] step_x,
	output logic init_ready,
	output logic step_ready,
	output logic step_done,
	output logic [lstm_pkg::N_HID*8-1:0] ct,
	output logic [lstm_pkg::N_HID*8-1:0] ht
);

	logic [lstm_pkg::N_LANE-1:0] w_we;
	logic [lstm_pkg::W_ADDR_BITS-1:0] w_addr;
	logic [lstm_pkg::ROW_BYTES*8-1:0] w_wdata;
	logic b_we;
	logic [lstm_pkg::W_ADDR_BITS-1:0] b_addr;
	logic [lstm_pkg::N_LANE*8-1:0] b_wdata;
	logic busy_write;
	logic rd_en;
	logic [lstm_pkg::W_ADDR_BITS-1:0] rd_addr;
	logic [lstm_pkg::N_LANE*lstm_pkg::ROW_BYTES*8-1:0] w_rdata;
	logic [lstm_pkg::N_LANE*8-1:0] b_rdata;
	logic capture_x;
	logic dot_en;
	logic [2:0] gate_phase;
	logic [1:0] pair_sel;
	logic commit_h;
	logic [lstm_pkg::N_IN*8-1:0] x_vec;
	logic [lstm_pkg::N_LANE-1:0][lstm_pkg::ACC_BITS-1:0] acc;

	param_loader u_loader (
		.clk(clk), .resetn(resetn), .init_valid(init_valid), .init_ready(init_ready),
		.init_type(init_type), .init_data(init_data), .w_we(w_we), .w_addr(w_addr),
		.w_wdata(w_wdata), .b_we(b_we), .b_addr(b_addr), .b_wdata(b_wdata),
		.busy_write(busy_write)
	);

	param_ram u_ram (
		.clk(clk), .w_we(w_we), .w_addr(w_addr), .w_wdata(w_wdata), .b_we(b_we),
		.b_addr(b_addr), .b_wdata(b_wdata), .rd_en(rd_en), .rd_addr(rd_addr),
		.w_rdata(w_rdata), .b_rdata(b_rdata)
	);

	step_ctrl u_ctrl (
		.clk(clk), .resetn(resetn), .step_valid(step_valid), .busy_write(busy_write),
		.step_ready(step_ready), .init_ready(init_ready), .step_done(step_done),
		.capture_x(capture_x), .rd_en(rd_en), .rd_addr(rd_addr), .dot_en(dot_en),
		.gate_phase(gate_phase), .pair_sel(pair_sel), .commit_h(commit_h)
	);

	// Hidden input of the dot product is the committed Ht
	dot_product u_dot (
		.clk(clk), .resetn(resetn), .en(dot_en), .x_vec(x_vec), .h_vec(ht),
		.w_row(w_rdata), .acc(acc)
	);

	cell_update u_cell (
		.clk(clk), .resetn(resetn), .step_x(step_x), .capture_x(capture_x),
		.gate_phase(gate_phase), .pair_sel(pair_sel), .commit_h(commit_h), .acc(acc),
		.b_rdata(b_rdata), .x_vec(x_vec), .ht(ht), .ct(ct)
	);

endmodule

// ==== rtl/cell_update.sv ====
// Gate requantization and activation, gate registers
// Cell and hidden state update with shadow Ht and commit at step end
`timescale 1ns/100ps

module cell_update (
	input  logic clk,
	input  logic resetn,
	input  logic [lstm_pkg::N_IN*8-1:0] step_x,
	input  logic capture_x,
	input  logic [2:0] gate_phase,
	input  logic [1:0] pair_sel,
	input  logic commit_h,
	input  logic [lstm_pkg::N_LANE-1:0][lstm_pkg::ACC_BITS-1:0] acc,
	input  logic [lstm_pkg::N_LANE*8-1:0] b_rdata,
	output logic [lstm_pkg::N_IN*8-1:0] x_vec,
	output logic [lstm_pkg::N_HID*8-1:0] ht,
	output logic [lstm_pkg::N_HID*8-1:0] ct
);
	import lstm_pkg::*;

	logic [N_LANE*8-1:0] b_q;
	logic [7:0] gate_f [N_LANE];
	logic [7:0] gate_i [N_LANE];
	logic [7:0] gate_g [N_LANE];
	logic [7:0] gate_o [N_LANE];
	logic [7:0] act_q [N_LANE];
	logic [7:0] c_new [N_LANE];
	logic [0:N_HID-1][7:0] c_state;
	logic [0:N_HID-1][7:0] c_out;
	logic [0:N_HID-1][7:0] h_shadow;
	logic [0:N_HID-1][7:0] h_out;
	logic [0:N_HID-1][7:0] h_next;
	logic [2:0] base;

	// Unit index of lane 0 in the current pair
	assign base = {pair_sel, 1'b0};
	assign ct = c_out;
	assign ht = h_out;

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////
	always_comb begin
		int scale;
		int c_dev;
		int ig;
		logic [7:0] t_in;
		logic [7:0] t_out;
		scale = (gate_phase[1:0] == GATE_G) ? SCALE_TANH : SCALE_SIG;
		h_next = h_shadow;
		for (int l = 0; l < N_LANE; l++) begin
			act_q[l] = act8(requant(int'($signed(acc[l])), b_q[(N_LANE-1-l)*8 +: 8], scale));
			// Old c in the cell phase, already updated c in the hidden phase
			c_dev = int'(c_state[base + 3'(l)]) - ZERO_STATE;
			ig = (int'(gate_i[l]) - OUT_ZERO_SIG) * (int'(gate_g[l]) - OUT_ZERO_TANH);
			c_new[l] = sat8(c_dev * (int'(gate_f[l]) - OUT_ZERO_SIG) / OUT_SCALE_SIG
				+ ig * SCALE_STATE / (OUT_SCALE_SIG * OUT_SCALE_TANH) + ZERO_STATE);
			t_in = sat8(c_dev * SCALE_TANH / SCALE_STATE + ZERO_ACT_IN);
			t_out = act8(t_in);
			h_next[base + 3'(l)] = sat8((int'(gate_o[l]) - OUT_ZERO_SIG)
				* (int'(t_out) - OUT_ZERO_TANH) * SCALE_DATA
				/ (OUT_SCALE_TANH * OUT_SCALE_SIG) + ZERO_DATA);
		end
	end

	// Bias read is one cycle ahead of the dot result
	always_ff @(posedge clk) begin
		b_q <= b_rdata;
		if (capture_x)
			x_vec <= step_x;
		if (gate_phase[2]) begin
			for (int l = 0; l < N_LANE; l++) begin
				case (gate_phase[1:0])
					GATE_F: gate_f[l] <= act_q[l];
					GATE_I: gate_i[l] <= act_q[l];
					GATE_G: gate_g[l] <= act_q[l];
					GATE_O: gate_o[l] <= act_q[l];
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// State registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			c_state <= {N_HID{8'(ZERO_STATE)}};
			c_out <= {N_HID{8'(ZERO_STATE)}};
			h_shadow <= {N_HID{8'(ZERO_DATA)}};
			h_out <= {N_HID{8'(ZERO_DATA)}};
		end else begin
			if (gate_phase == PH_CELL) begin
				for (int l = 0; l < N_LANE; l++)
					c_state[base + 3'(l)] <= c_new[l];
			end
			if (gate_phase == PH_HID)
				h_shadow <= h_next;
			// Dot products of the whole step see the old Ht
			if (commit_h) begin
				h_out <= h_next;
				c_out <= c_state;
			end
		end
	end

endmodule

// ==== rtl/dot_product.sv ====
// Two-lane 16-term signed inner product
// Zero points removed from data and weights, sums registered
`timescale 1ns/100ps

module dot_product (
	input  logic clk,
	input  logic resetn,
	input  logic en,
	input  logic [lstm_pkg::N_IN*8-1:0] x_vec,
	input  logic [lstm_pkg::N_HID*8-1:0] h_vec,
	input  logic [lstm_pkg::N_LANE*lstm_pkg::ROW_BYTES*8-1:0] w_row,
	output logic [lstm_pkg::N_LANE-1:0][lstm_pkg::ACC_BITS-1:0] acc
);
	import lstm_pkg::*;

	// Term 0 is x0 in the top byte, term 15 is h7
	logic [0:N_TERM-1][7:0] data;
	logic [N_LANE-1:0][ACC_BITS-1:0] sum;

	assign data = {x_vec, h_vec};

	always_comb begin
		int total;
		int dv;
		int wv;
		for (int l = 0; l < N_LANE; l++) begin
			total = 0;
			for (int t = 0; t < N_TERM; t++) begin
				dv = int'(data[t]) - ZERO_DATA;
				wv = int'(w_row[(N_LANE-l)*ROW_BYTES*8 - 8*t - 1 -: 8]) - ZERO_W;
				total = total + dv * wv;
			end
			sum[l] = ACC_BITS'(total);
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			acc <= '0;
		else if (en)
			acc <= sum;
	end

endmodule

// ==== rtl/step_ctrl.sv ====
// Step FSM with cycle counter
// Read addresses, dot enable and gate phase schedule for the four unit pairs
`timescale 1ns/100ps

module step_ctrl (
	input  logic clk,
	input  logic resetn,
	input  logic step_valid,
	input  logic busy_write,
	output logic step_ready,
	output logic init_ready,
	output logic step_done,
	output logic capture_x,
	output logic rd_en,
	output logic [lstm_pkg::W_ADDR_BITS-1:0] rd_addr,
	output logic dot_en,
	output logic [2:0] gate_phase,
	output logic [1:0] pair_sel,
	output logic commit_h
);
	import lstm_pkg::*;

	// FSM state, high while a step runs
	logic running;
	logic [4:0] cnt;
	logic [2:0] pair_idx;
	logic [2:0] slot;
	logic last;
	logic active;

	assign step_ready = !running && !busy_write;
	assign init_ready = !running;
	assign capture_x = step_valid && step_ready;
	assign last = running && cnt == 5'(STEP_LATENCY - 1);
	assign commit_h = last;

	// Counter equals the cycle index after accept, so pair 0 reads in the accept cycle
	assign active = running || capture_x;
	assign pair_idx = 3'(cnt / 5'(PAIR_CYCLES));
	assign slot = 3'(cnt % 5'(PAIR_CYCLES));
	assign rd_en = active && pair_idx < 3'(N_PAIR) && slot < 3'(N_GATE);
	assign rd_addr = {pair_idx[1:0], slot[1:0]};

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			running <= 1'b0;
			cnt <= '0;
			step_done <= 1'b0;
		end else begin
			step_done <= last;
			if (capture_x) begin
				running <= 1'b1;
				cnt <= 5'd1;
			end else if (last) begin
				running <= 1'b0;
				cnt <= '0;
			end else if (running) begin
				cnt <= cnt + 5'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Per-cycle phase decode
	////////////////////////////////////////////////////////////
	always_comb begin
		gate_phase = PH_IDLE;
		pair_sel = pair_idx[1:0];
		dot_en = 1'b0;
		if (running) begin
			if (pair_idx < 3'(N_PAIR) && slot >= 3'd1 && slot <= 3'(N_GATE))
				dot_en = 1'b1;
			if (pair_idx < 3'(N_PAIR) && slot >= 3'd2) begin
				gate_phase = PH_GATE | {1'b0, 2'(slot - 3'd2)};
			end else if (pair_idx != 3'd0 && slot == 3'd0) begin
				// Previous pair, overlapping the next reads
				gate_phase = PH_CELL;
				pair_sel = 2'(pair_idx - 3'd1);
			end else if (pair_idx != 3'd0 && slot == 3'd1) begin
				gate_phase = PH_HID;
				pair_sel = 2'(pair_idx - 3'd1);
			end
		end
	end

endmodule

// ==== rtl/param_ram.sv ====
// Weight memories for both lanes and the paired bias memory
// Synchronous read, write wins over read
`timescale 1ns/100ps

module param_ram (
	input  logic clk,
	input  logic [lstm_pkg::N_LANE-1:0] w_we,
	input  logic [lstm_pkg::W_ADDR_BITS-1:0] w_addr,
	input  logic [lstm_pkg::ROW_BYTES*8-1:0] w_wdata,
	input  logic b_we,
	input  logic [lstm_pkg::W_ADDR_BITS-1:0] b_addr,
	input  logic [lstm_pkg::N_LANE*8-1:0] b_wdata,
	input  logic rd_en,
	input  logic [lstm_pkg::W_ADDR_BITS-1:0] rd_addr,
	output logic [lstm_pkg::N_LANE*lstm_pkg::ROW_BYTES*8-1:0] w_rdata,
	output logic [lstm_pkg::N_LANE*8-1:0] b_rdata
);
	import lstm_pkg::*;

	logic [ROW_BYTES*8-1:0] w_mem [N_LANE][W_ROWS];
	logic [N_LANE*8-1:0] b_mem [W_ROWS];

	// Lane 0 row is returned in the upper half
	always_ff @(posedge clk) begin
		for (int l = 0; l < N_LANE; l++) begin
			if (w_we[l])
				w_mem[l][w_addr] <= w_wdata;
			else if (rd_en)
				w_rdata[(N_LANE-1-l)*ROW_BYTES*8 +: ROW_BYTES*8] <= w_mem[l][rd_addr];
		end
	end

	always_ff @(posedge clk) begin
		if (b_we)
			b_mem[b_addr] <= b_wdata;
		else if (rd_en)
			b_rdata <= b_mem[rd_addr];
	end

endmodule

// ==== rtl/param_loader.sv ====
// Init stream packer for weight rows and bias pairs
// Issues one memory write after each completed row or pair
`timescale 1ns/100ps

module param_loader (
	input  logic clk,
	input  logic resetn,
	input  logic init_valid,
	input  logic init_ready,
	input  logic init_type,
	input  logic [7:0] init_data,
	output logic [lstm_pkg::N_LANE-1:0] w_we,
	output logic [lstm_pkg::W_ADDR_BITS-1:0] w_addr,
	output logic [lstm_pkg::ROW_BYTES*8-1:0] w_wdata,
	output logic b_we,
	output logic [lstm_pkg::W_ADDR_BITS-1:0] b_addr,
	output logic [lstm_pkg::N_LANE*8-1:0] b_wdata,
	output logic busy_write
);
	import lstm_pkg::*;

	logic xfer;
	logic row_done;
	logic pair_done;
	logic [3:0] byte_cnt;
	logic [4:0] row_cnt;
	logic [4:0] bias_cnt;
	logic [ROW_BYTES*8-1:0] row_buf;
	logic [ROW_BYTES*8-1:0] row_next;

	assign xfer = init_valid && init_ready;
	// First byte of a row ends up in the top bits
	assign row_next = {row_buf[ROW_BYTES*8-9:0], init_data};
	assign row_done = xfer && init_type == INIT_WEIGHT && byte_cnt == 4'(ROW_BYTES - 1);
	assign pair_done = xfer && init_type == INIT_BIAS && bias_cnt[0];
	assign busy_write = (|w_we) || b_we;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			byte_cnt <= '0;
			row_cnt <= '0;
			bias_cnt <= '0;
			w_we <= '0;
			b_we <= 1'b0;
		end else begin
			w_we <= '0;
			b_we <= pair_done;
			if (xfer && init_type == INIT_WEIGHT)
				byte_cnt <= byte_cnt + 4'd1;
			if (xfer && init_type == INIT_BIAS)
				bias_cnt <= bias_cnt + 5'd1;
			if (row_done) begin
				// Even rows to lane 0, odd rows to lane 1
				w_we[row_cnt[0]] <= 1'b1;
				row_cnt <= row_cnt + 5'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (xfer)
			row_buf <= row_next;
		if (row_done) begin
			w_addr <= row_cnt[4:1];
			w_wdata <= row_next;
		end
		if (pair_done) begin
			b_addr <= bias_cnt[4:1];
			b_wdata <= row_next[N_LANE*8-1:0];
		end
	end

endmodule

// ==== rtl/lstm_pkg.sv ====
// Sizes, quantization constants, phase codes and step timing of the LSTM cell
// Saturation, requantization and hard activation functions
package lstm_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int N_IN = 8;
	localparam int N_HID = 8;
	localparam int N_LANE = 2;
	localparam int N_TERM = N_IN + N_HID;
	localparam int N_GATE = 4;
	localparam int N_PAIR = N_HID / N_LANE;
	localparam int ROW_BYTES = N_TERM;
	localparam int W_ADDR_BITS = 4;
	localparam int W_ROWS = N_GATE * N_HID / N_LANE;
	localparam int ACC_BITS = 21;

	// Zero points
	localparam int ZERO_DATA = 128;
	localparam int ZERO_STATE = 128;
	localparam int ZERO_W = 128;
	localparam int ZERO_B = 0;
	localparam int ZERO_ACT_IN = 128;
	localparam int OUT_ZERO_SIG = 0;
	localparam int OUT_ZERO_TANH = 128;

	// Scales
	localparam int SCALE_DATA = 128;
	localparam int SCALE_STATE = 128;
	localparam int SCALE_W = 128;
	localparam int SCALE_B = 256;
	localparam int SCALE_SIG = 24;
	localparam int SCALE_TANH = 48;
	localparam int OUT_SCALE_SIG = 256;
	localparam int OUT_SCALE_TANH = 128;

	// Gate order inside a weight row group
	localparam logic [1:0] GATE_F = 2'd0;
	localparam logic [1:0] GATE_I = 2'd1;
	localparam logic [1:0] GATE_G = 2'd2;
	localparam logic [1:0] GATE_O = 2'd3;

	localparam logic INIT_WEIGHT = 1'b0;
	localparam logic INIT_BIAS = 1'b1;

	////////////////////////////////////////////////////////////
	// Step schedule
	////////////////////////////////////////////////////////////
	localparam int STEP_LATENCY = 26;
	localparam int PAIR_CYCLES = N_GATE + 2;

	// Gate phases carry the gate index in the low bits
	localparam logic [2:0] PH_IDLE = 3'b000;
	localparam logic [2:0] PH_CELL = 3'b001;
	localparam logic [2:0] PH_HID = 3'b010;
	localparam logic [2:0] PH_GATE = 3'b100;

	// Clamp to the unsigned byte range
	function automatic logic [7:0] sat8(input int v);
		if (v < 0)
			return 8'h00;
		if (v > 255)
			return 8'hff;
		return v[7:0];
	endfunction

	// Dot result and bias into the activation input domain
	function automatic logic [7:0] requant(input int dot, input logic [7:0] bias, input int scale);
		int dot_part;
		int bias_part;
		dot_part = dot * scale / (SCALE_W * SCALE_DATA);
		bias_part = (int'(bias) - ZERO_B) * scale / SCALE_B;
		return sat8(dot_part + bias_part + ZERO_ACT_IN);
	endfunction

	// Hard sigmoid and hard tanh share the slope 8/3
	function automatic logic [7:0] act8(input logic [7:0] q);
		return sat8(ZERO_ACT_IN + (int'(q) - ZERO_ACT_IN) * 8 / 3);
	endfunction

endpackage
